// ==== hw/isaPkg.sv ====
`default_nettype none

package isaPkg;

        typedef logic [15:0] word_t;
        typedef logic [2:0]  regIdx_t;

        typedef enum logic [4:0] {
                OpHalt  = 5'b00000,
                OpNop   = 5'b00001,
                OpJ     = 5'b00100,
                OpJr    = 5'b00101,
                OpJal   = 5'b00110,
                OpJalr  = 5'b00111,
                OpAddi  = 5'b01000,
                OpSubi  = 5'b01001,
                OpXori  = 5'b01010,
                OpAndni = 5'b01011,
                OpBeqz  = 5'b01100,
                OpBnez  = 5'b01101,
                OpBltz  = 5'b01110,
                OpBgez  = 5'b01111,
                OpSt    = 5'b10000,
                OpLd    = 5'b10001,
                OpSlbi  = 5'b10010,
                OpStu   = 5'b10011,
                OpRoli  = 5'b10100,
                OpSlli  = 5'b10101,
                OpRori  = 5'b10110,
                OpSrli  = 5'b10111,
                OpLbi   = 5'b11000,
                OpBtr   = 5'b11001,
                OpRot   = 5'b11010,  // ROL SLL ROR SRL by funct
                OpArith = 5'b11011,  // ADD SUB XOR ANDN by funct
                OpSeq   = 5'b11100,
                OpSlt   = 5'b11101,
                OpSle   = 5'b11110,
                OpSco   = 5'b11111
        } opcode_e;

        typedef enum logic [3:0] {
                AluAdd, AluXor, AluAndn, AluRol, AluSll, AluRor, AluSrl,
                AluSeq, AluSlt, AluSle, AluSco, AluBtr, AluLbi, AluSlbi
        } aluOp_e;

        typedef enum logic [1:0] {DstRdI, DstRs, DstRdR, DstR7} dstSel_e;
        typedef enum logic [1:0] {ResPc2, ResMem, ResAlu, ResFlag} resSel_e;
        typedef enum logic [1:0] {BRt, BImm5, BImm8} bSel_e;
        typedef enum logic [2:0] {BrNone, BrEqz, BrNez, BrLtz, BrGez, BrJmp} brKind_e;

        typedef struct packed {
                opcode_e         opcode;
                regIdx_t         rs;
                regIdx_t         rt;
                regIdx_t         rd;
                logic [1:0]      funct;
        } rFmt_t;

        typedef struct packed {
                opcode_e         opcode;
                regIdx_t         rs;
                regIdx_t         rd;
                logic [4:0]      imm5;
        } iFmt1_t;

        typedef struct packed {
                opcode_e         opcode;
                regIdx_t         rs;
                logic [7:0]      imm8;
        } iFmt2_t;

        typedef struct packed {
                opcode_e         opcode;
                logic [10:0]     disp11;
        } jFmt_t;

        typedef union packed {
                rFmt_t  rFmt;
                iFmt1_t iFmt1;
                iFmt2_t iFmt2;
                jFmt_t  jFmt;
        } instr_u;

        typedef struct packed {
                logic    regWrt;
                logic    memWrt;
                logic    memRead;
                logic    zeroExt;
                logic    invA;
                logic    invB;
                logic    cin;
                logic    aluJmp;  // Jump target from rs
                logic    halt;
                logic    err;
                aluOp_e  aluOp;
                dstSel_e dstSel;
                resSel_e resSel;
                bSel_e   bSel;
                brKind_e brKind;
        } ctrl_t;

        typedef struct packed {
                logic    valid;
                regIdx_t idx;
                word_t   data;
        } wb_t;

endpackage

`default_nettype wire

// ==== hw/ctrlDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlDecode (
        input  isaPkg::instr_u instr,
        output isaPkg::ctrl_t  ctrl
);

        function automatic isaPkg::aluOp_e shiftOp(input logic [1:0] sel);
                return isaPkg::aluOp_e'(4'(isaPkg::AluRol) + {2'b00, sel});
        endfunction

        always_comb begin
                ctrl        = '0;
                ctrl.aluOp  = isaPkg::AluAdd;
                ctrl.dstSel = isaPkg::DstRdI;
                ctrl.resSel = isaPkg::ResAlu;
                ctrl.bSel   = isaPkg::BRt;
                ctrl.brKind = isaPkg::BrNone;

                case (instr.rFmt.opcode)
                        isaPkg::OpHalt: ctrl.halt = 1'b1;
                        isaPkg::OpNop: ;

                        isaPkg::OpAddi, isaPkg::OpSubi, isaPkg::OpXori, isaPkg::OpAndni,
                        isaPkg::OpRoli, isaPkg::OpSlli, isaPkg::OpRori, isaPkg::OpSrli: begin
                                ctrl.regWrt = 1'b1;
                                ctrl.bSel   = isaPkg::BImm5;
                                case (instr.rFmt.opcode)
                                        isaPkg::OpSubi: begin
                                                ctrl.invA = 1'b1;  // imm minus rs
                                                ctrl.cin  = 1'b1;
                                        end
                                        isaPkg::OpXori: begin
                                                ctrl.zeroExt = 1'b1;
                                                ctrl.aluOp   = isaPkg::AluXor;
                                        end
                                        isaPkg::OpAndni: begin
                                                ctrl.zeroExt = 1'b1;
                                                ctrl.invB    = 1'b1;
                                                ctrl.aluOp   = isaPkg::AluAndn;
                                        end
                                        isaPkg::OpAddi: ;
                                        default: begin
                                                ctrl.zeroExt = 1'b1;
                                                ctrl.aluOp   = shiftOp(instr.rFmt.opcode[1:0]);
                                        end
                                endcase
                        end

                        isaPkg::OpSt: begin
                                ctrl.memWrt = 1'b1;
                                ctrl.bSel   = isaPkg::BImm5;
                        end
                        isaPkg::OpLd: begin
                                ctrl.regWrt  = 1'b1;
                                ctrl.memRead = 1'b1;
                                ctrl.bSel    = isaPkg::BImm5;
                                ctrl.resSel  = isaPkg::ResMem;
                        end
                        isaPkg::OpStu: begin
                                ctrl.regWrt = 1'b1;
                                ctrl.memWrt = 1'b1;
                                ctrl.bSel   = isaPkg::BImm5;
                                ctrl.dstSel = isaPkg::DstRs;  // Address back to rs
                        end

                        isaPkg::OpLbi, isaPkg::OpSlbi: begin
                                ctrl.regWrt  = 1'b1;
                                ctrl.dstSel  = isaPkg::DstRs;
                                ctrl.bSel    = isaPkg::BImm8;
                                ctrl.zeroExt = instr.rFmt.opcode == isaPkg::OpSlbi;
                                ctrl.aluOp   = (instr.rFmt.opcode == isaPkg::OpSlbi) ?
                                               isaPkg::AluSlbi : isaPkg::AluLbi;
                        end

                        isaPkg::OpBtr, isaPkg::OpRot, isaPkg::OpArith: begin
                                ctrl.regWrt = 1'b1;
                                ctrl.dstSel = isaPkg::DstRdR;
                                if (instr.rFmt.opcode == isaPkg::OpBtr) begin
                                        ctrl.aluOp = isaPkg::AluBtr;
                                end else if (instr.rFmt.opcode == isaPkg::OpRot) begin
                                        ctrl.aluOp = shiftOp(instr.rFmt.funct);
                                end else begin
                                        case (instr.rFmt.funct)
                                                2'b00: ctrl.aluOp = isaPkg::AluAdd;
                                                2'b01: begin
                                                        ctrl.invA = 1'b1;  // rt minus rs
                                                        ctrl.cin  = 1'b1;
                                                end
                                                2'b10: ctrl.aluOp = isaPkg::AluXor;
                                                default: begin
                                                        ctrl.invB  = 1'b1;
                                                        ctrl.aluOp = isaPkg::AluAndn;
                                                end
                                        endcase
                                end
                        end

                        isaPkg::OpSeq, isaPkg::OpSlt, isaPkg::OpSle, isaPkg::OpSco: begin
                                ctrl.regWrt = 1'b1;
                                ctrl.dstSel = isaPkg::DstRdR;
                                ctrl.resSel = isaPkg::ResFlag;
                                ctrl.aluOp  = isaPkg::aluOp_e'(4'(isaPkg::AluSeq) +
                                                               {2'b00, instr.rFmt.opcode[1:0]});
                        end

                        isaPkg::OpBeqz: ctrl.brKind = isaPkg::BrEqz;
                        isaPkg::OpBnez: ctrl.brKind = isaPkg::BrNez;
                        isaPkg::OpBltz: ctrl.brKind = isaPkg::BrLtz;
                        isaPkg::OpBgez: ctrl.brKind = isaPkg::BrGez;

                        isaPkg::OpJ, isaPkg::OpJr, isaPkg::OpJal, isaPkg::OpJalr: begin
                                ctrl.brKind = isaPkg::BrJmp;
                                ctrl.aluJmp = instr.rFmt.opcode[0];  // JR and JALR
                                if (instr.rFmt.opcode[1]) begin
                                        ctrl.regWrt = 1'b1;  // Link into r7
                                        ctrl.dstSel = isaPkg::DstR7;
                                        ctrl.resSel = isaPkg::ResPc2;
                                end
                        end

                        default: ctrl.err = 1'b1;  // SIIC, RTI and unused codes
                endcase
        end

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
        input  logic            clk,
        input  logic            rstN,
        input  logic            wrEn,
        input  isaPkg::regIdx_t wrIdx,
        input  isaPkg::word_t   wrData,
        input  isaPkg::regIdx_t rdIdxA,
        input  isaPkg::regIdx_t rdIdxB,
        output isaPkg::word_t   rdDataA,
        output isaPkg::word_t   rdDataB
);

        isaPkg::word_t regs [8];

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < 8; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wrEn) begin
                        regs[wrIdx] <= wrData;
                end
        end

        // Old value until the edge
        assign rdDataA = regs[rdIdxA];
        assign rdDataB = regs[rdIdxB];

endmodule

`default_nettype wire

// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
        input  isaPkg::word_t a,
        input  isaPkg::word_t b,
        input  isaPkg::ctrl_t ctrl,
        output isaPkg::word_t result,
        output logic          flag
);

        isaPkg::word_t aOp;
        isaPkg::word_t bOp;
        isaPkg::word_t sum;
        logic          carry;
        logic [3:0]    sh;
        logic [31:0]   rolWide;
        logic [31:0]   rorWide;

        assign aOp = ctrl.invA ? ~a : a;
        assign bOp = ctrl.invB ? ~b : b;
        assign {carry, sum} = 17'(aOp) + 17'(bOp) + 17'(ctrl.cin);

        assign sh      = b[3:0];
        assign rolWide = {a, a} << sh;
        assign rorWide = {a, a} >> sh;

        always_comb begin
                case (ctrl.aluOp)
                        isaPkg::AluXor:  result = aOp ^ bOp;
                        isaPkg::AluAndn: result = aOp & bOp;  // b already inverted
                        isaPkg::AluRol:  result = rolWide[31:16];
                        isaPkg::AluSll:  result = a << sh;
                        isaPkg::AluRor:  result = rorWide[15:0];
                        isaPkg::AluSrl:  result = a >> sh;
                        isaPkg::AluBtr:  result = {<<{a}};
                        isaPkg::AluLbi:  result = b;
                        isaPkg::AluSlbi: result = {a[7:0], 8'h00} | b;
                        default:         result = sum;
                endcase
        end

        always_comb begin
                case (ctrl.aluOp)
                        isaPkg::AluSeq: flag = a == b;
                        isaPkg::AluSlt: flag = $signed(a) < $signed(b);
                        isaPkg::AluSle: flag = $signed(a) <= $signed(b);
                        isaPkg::AluSco: flag = carry;  // Unsigned carry of a plus b
                        default:        flag = 1'b0;
                endcase
        end

        aluOpKnown: assert property (@(ctrl.aluOp) ctrl.aluOp <= isaPkg::AluSlbi)
                else $error("aluUnit: undefined aluOp %0d", ctrl.aluOp);

endmodule

`default_nettype wire

// ==== hw/nextPc.sv ====
`timescale 1ns/1ps
`default_nettype none

module nextPc (
        input  isaPkg::word_t  pc,
        input  isaPkg::word_t  rsVal,
        input  isaPkg::instr_u instr,
        input  isaPkg::ctrl_t  ctrl,
        output isaPkg::word_t  pcNext
);

        isaPkg::word_t pcPlus2;
        isaPkg::word_t imm8Sx;
        isaPkg::word_t disp11Sx;
        logic          taken;

        assign pcPlus2  = pc + 16'd2;
        assign imm8Sx   = {{8{instr.iFmt2.imm8[7]}}, instr.iFmt2.imm8};
        assign disp11Sx = {{5{instr.jFmt.disp11[10]}}, instr.jFmt.disp11};

        always_comb begin
                case (ctrl.brKind)
                        isaPkg::BrEqz: taken = rsVal == '0;
                        isaPkg::BrNez: taken = rsVal != '0;
                        isaPkg::BrLtz: taken = rsVal[15];
                        isaPkg::BrGez: taken = !rsVal[15];
                        default:       taken = 1'b0;
                endcase
        end

        always_comb begin
                if (ctrl.brKind == isaPkg::BrJmp) begin
                        pcNext = ctrl.aluJmp ? rsVal + imm8Sx : pcPlus2 + disp11Sx;
                end else if (taken) begin
                        pcNext = pcPlus2 + imm8Sx;
                end else begin
                        pcNext = pcPlus2;
                end
        end

endmodule

`default_nettype wire

// ==== hw/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
        parameter int DataMemWords
) (
        input  logic          clk,
        input  logic          wrEn,
        input  isaPkg::word_t addr,
        input  isaPkg::word_t wrData,
        output isaPkg::word_t rdData
);

        localparam int IdxBits = $clog2(DataMemWords);

        isaPkg::word_t      mem [DataMemWords];
        logic [IdxBits-1:0] wordIdx;

        assign wordIdx = addr[IdxBits:1];  // Byte address to word index

        always_ff @(posedge clk) begin
                if (wrEn) begin
                        mem[wordIdx] <= wrData;
                end
        end

        assign rdData = mem[wordIdx];

endmodule

`default_nettype wire

// ==== hw/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
        parameter int DataMemWords = 256
) (
        input  logic           clk,
        input  logic           rstN,
        input  isaPkg::instr_u instr,
        output isaPkg::word_t  pc,
        output isaPkg::wb_t    wb,
        output logic           halted,
        output logic           err
);

        isaPkg::ctrl_t ctrl;
        isaPkg::word_t rsVal;
        isaPkg::word_t rtVal;
        isaPkg::word_t bOp;
        isaPkg::word_t aluRes;
        isaPkg::word_t memAddr;
        isaPkg::word_t memData;
        isaPkg::word_t pcNext;
        logic          flag;
        logic          commit;

        assign commit = rstN && !halted && !err;  // Nothing lands in reset or once stopped

        ctrlDecode ctrlDecode_inst (.instr(instr), .ctrl(ctrl));

        regFile regFile_inst (
                .clk(clk), .rstN(rstN),
                .wrEn(wb.valid), .wrIdx(wb.idx), .wrData(wb.data),
                .rdIdxA(instr.rFmt.rs), .rdIdxB(instr.rFmt.rt),
                .rdDataA(rsVal), .rdDataB(rtVal)
        );

        always_comb begin
                case (ctrl.bSel)
                        isaPkg::BImm5: bOp = ctrl.zeroExt ? {11'b0, instr.iFmt1.imm5} :
                                             {{11{instr.iFmt1.imm5[4]}}, instr.iFmt1.imm5};
                        isaPkg::BImm8: bOp = ctrl.zeroExt ? {8'b0, instr.iFmt2.imm8} :
                                             {{8{instr.iFmt2.imm8[7]}}, instr.iFmt2.imm8};
                        default:       bOp = rtVal;
                endcase
        end

        aluUnit aluUnit_inst (.a(rsVal), .b(bOp), .ctrl(ctrl), .result(aluRes), .flag(flag));

        nextPc nextPc_inst (.pc(pc), .rsVal(rsVal), .instr(instr), .ctrl(ctrl), .pcNext(pcNext));

        assign memAddr = (ctrl.memRead || ctrl.memWrt) ? aluRes : '0;

        // Store data is the iFmt1 rd, read through the rt port
        dataMem #(.DataMemWords(DataMemWords)) dataMem_inst (
                .clk(clk), .wrEn(ctrl.memWrt && commit),
                .addr(memAddr), .wrData(rtVal), .rdData(memData)
        );

        always_comb begin
                wb.valid = ctrl.regWrt && commit;
                case (ctrl.dstSel)
                        isaPkg::DstRs:  wb.idx = instr.iFmt1.rs;
                        isaPkg::DstRdR: wb.idx = instr.rFmt.rd;
                        isaPkg::DstR7:  wb.idx = 3'd7;
                        default:        wb.idx = instr.iFmt1.rd;
                endcase
                case (ctrl.resSel)
                        isaPkg::ResPc2:  wb.data = pc + 16'd2;
                        isaPkg::ResMem:  wb.data = memData;
                        isaPkg::ResFlag: wb.data = {15'b0, flag};
                        default:         wb.data = aluRes;
                endcase
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        pc     <= '0;
                        halted <= 1'b0;
                        err    <= 1'b0;
                end else if (!halted && !err) begin
                        halted <= ctrl.halt;
                        err    <= ctrl.err;
                        if (!ctrl.halt && !ctrl.err) begin
                                pc <= pcNext;  // Stopped PC stays on the last fetch
                        end
                end
        end

        pcEven: assert property (@(posedge clk) disable iff (!rstN) !pc[0])
                else $error("cpuCore: odd pc %h", pc);

        // Covers the stopping instruction itself as well
        noWbStopped: assert property (@(posedge clk) disable iff (!rstN)
                        (halted || err || ctrl.halt || ctrl.err) |-> !wb.valid)
                else $error("cpuCore: write-back after stop");

endmodule

`default_nettype wire

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

        localparam int CycleLimit = 64 * 6;

        logic            clk;
        logic            rstN;
        isaPkg::instr_u  instr;
        isaPkg::word_t   pc;
        isaPkg::wb_t     wb;
        logic            halted;
        logic            err;

        isaPkg::word_t   rom [256];
        int              progLen;
        int              cycles;
        isaPkg::word_t   stopPc;
        isaPkg::word_t   model [8];
        isaPkg::regIdx_t expIdx [$];
        isaPkg::word_t   expData [$];
        isaPkg::regIdx_t gotIdx [$];
        isaPkg::word_t   gotData [$];

        cpuCore #(.DataMemWords(256)) cpuCore_inst (
                .clk(clk), .rstN(rstN), .instr(instr),
                .pc(pc), .wb(wb), .halted(halted), .err(err)
        );

        assign instr = rom[pc[8:1]];  // Fetch in the same cycle

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        initial begin
                cycles = 0;
                forever begin
                        @(posedge clk);
                        cycles++;
                        if (cycles > CycleLimit) begin
                                $display("Timeout: core did not stop within %0d cycles", CycleLimit);
                                $display("Regression failed");
                                $fatal(1);
                        end
                end
        end

        always @(negedge clk) begin
                if (rstN && wb.valid) begin
                        gotIdx.push_back(wb.idx);
                        gotData.push_back(wb.data);
                end
        end

        task automatic checkEq(input string name, input isaPkg::word_t expVal,
                               input isaPkg::word_t actVal);
                if (expVal !== actVal) begin
                        $display("Error: %s expected %h actual %h", name, expVal, actVal);
                        $display("Regression failed");
                        $fatal(1);
                end
        endtask

        function automatic isaPkg::word_t sx5(input logic [4:0] imm);
                return {{11{imm[4]}}, imm};
        endfunction

        function automatic isaPkg::word_t rotLeft(input isaPkg::word_t w, input logic [3:0] s);
                isaPkg::word_t r;
                for (int i = 0; i < 16; i++) begin
                        r[(i + s) % 16] = w[i];
                end
                return r;
        endfunction

        function automatic isaPkg::word_t rotRight(input isaPkg::word_t w, input logic [3:0] s);
                isaPkg::word_t r;
                for (int i = 0; i < 16; i++) begin
                        r[i] = w[(i + s) % 16];
                end
                return r;
        endfunction

        function automatic isaPkg::word_t bitRev(input isaPkg::word_t w);
                isaPkg::word_t r;
                for (int i = 0; i < 16; i++) begin
                        r[15 - i] = w[i];
                end
                return r;
        endfunction

        task automatic startProgram();
                for (int i = 0; i < 256; i++) begin
                        rom[i] = {5'b00000, 11'(i)};  // HALT everywhere
                end
                for (int i = 0; i < 8; i++) begin
                        model[i] = '0;
                end
                progLen = 0;
                stopPc = '0;
                expIdx.delete();
                expData.delete();
        endtask

        task automatic emit(input isaPkg::word_t w);
                rom[progLen] = w;
                progLen++;
        endtask

        task automatic emitStop(input isaPkg::word_t w);
                stopPc = 16'(2 * progLen);  // PC freezes on the stopping instruction
                emit(w);
        endtask

        task automatic setReg(input isaPkg::regIdx_t r, input isaPkg::word_t v);
                model[r] = v;
                expIdx.push_back(r);
                expData.push_back(v);
        endtask

        task automatic lbi(input isaPkg::regIdx_t r, input logic [7:0] imm);
                emit({isaPkg::OpLbi, r, imm});
                setReg(r, {{8{imm[7]}}, imm});
        endtask

        task automatic loadWord(input isaPkg::regIdx_t r, input isaPkg::word_t v);
                lbi(r, v[15:8]);
                emit({isaPkg::OpSlbi, r, v[7:0]});
                setReg(r, {model[r][7:0], v[7:0]});
        endtask

        task automatic iOp(input logic [4:0] op, input isaPkg::regIdx_t rs,
                           input isaPkg::regIdx_t rd, input logic [4:0] imm,
                           input isaPkg::word_t v);
                emit({op, rs, rd, imm});
                setReg(rd, v);
        endtask

        task automatic rOp(input logic [4:0] op, input isaPkg::regIdx_t rs,
                           input isaPkg::regIdx_t rt, input isaPkg::regIdx_t rd,
                           input logic [1:0] funct, input isaPkg::word_t v);
                emit({op, rs, rt, rd, funct});
                setReg(rd, v);
        endtask

        task automatic skipped();
                emit({isaPkg::OpLbi, 3'd6, 8'h5a});  // Must never write
        endtask

        task automatic runProgram(input string name, input logic expHalt, input logic expErr);
                @(posedge clk);
                #2 rstN = 1'b0;
                repeat (2) @(posedge clk);
                gotIdx.delete();
                gotData.delete();
                #2 rstN = 1'b1;
                do @(negedge clk); while (!(halted || err));
                @(negedge clk);
                checkEq({name, " halted"}, {15'b0, expHalt}, {15'b0, halted});
                checkEq({name, " err"}, {15'b0, expErr}, {15'b0, err});
                checkEq({name, " pc"}, stopPc, pc);
                checkEq({name, " write count"}, 16'(expIdx.size()), 16'(gotIdx.size()));
                for (int i = 0; i < expIdx.size(); i++) begin
                        checkEq($sformatf("%s idx %0d", name, i), {13'b0, expIdx[i]},
                                {13'b0, gotIdx[i]});
                        checkEq($sformatf("%s data %0d", name, i), expData[i], gotData[i]);
                end
        endtask

        task automatic testImmediate();
                isaPkg::word_t a;
                logic [4:0]    imm [8];
                a = 16'($urandom);
                for (int i = 0; i < 8; i++) begin
                        imm[i] = 5'($urandom);
                end
                startProgram();
                loadWord(1, a);
                iOp(isaPkg::OpAddi, 1, 2, imm[0], a + sx5(imm[0]));
                iOp(isaPkg::OpSubi, 1, 3, imm[1], sx5(imm[1]) - a);  // imm minus rs
                iOp(isaPkg::OpXori, 1, 4, imm[2], a ^ {11'b0, imm[2]});
                iOp(isaPkg::OpAndni, 1, 5, imm[3], a & ~{11'b0, imm[3]});
                iOp(isaPkg::OpRoli, 1, 2, imm[4], rotLeft(a, imm[4][3:0]));
                iOp(isaPkg::OpSlli, 1, 3, imm[5], a << imm[5][3:0]);
                iOp(isaPkg::OpRori, 1, 4, imm[6], rotRight(a, imm[6][3:0]));
                iOp(isaPkg::OpSrli, 1, 5, imm[7], a >> imm[7][3:0]);
                emitStop(16'h0000);
                runProgram("immediate", 1'b1, 1'b0);
        endtask

        task automatic testRegister();
                isaPkg::word_t a;
                isaPkg::word_t b;
                a = 16'($urandom);
                b = 16'($urandom);
                startProgram();
                loadWord(1, a);
                loadWord(2, b);
                rOp(isaPkg::OpArith, 1, 2, 3, 2'd0, a + b);
                rOp(isaPkg::OpArith, 1, 2, 4, 2'd1, b - a);
                rOp(isaPkg::OpArith, 1, 2, 5, 2'd2, a ^ b);
                rOp(isaPkg::OpArith, 1, 2, 6, 2'd3, a & ~b);
                rOp(isaPkg::OpRot, 1, 2, 3, 2'd0, rotLeft(a, b[3:0]));
                rOp(isaPkg::OpRot, 1, 2, 4, 2'd1, a << b[3:0]);
                rOp(isaPkg::OpRot, 1, 2, 5, 2'd2, rotRight(a, b[3:0]));
                rOp(isaPkg::OpRot, 1, 2, 6, 2'd3, a >> b[3:0]);
                rOp(isaPkg::OpBtr, 1, 0, 7, 2'd0, bitRev(a));
                emitStop(16'h0000);
                runProgram("register", 1'b1, 1'b0);
        endtask

        task automatic testCompare();
                isaPkg::word_t a [4];
                isaPkg::word_t b [4];
                a[0] = 16'($urandom);
                b[0] = 16'($urandom);
                a[1] = 16'($urandom);
                b[1] = a[1];                       // Equal pair
                a[2] = 16'h7fff;
                b[2] = 16'h8000;                   // Signed extremes
                a[3] = 16'hffff;
                b[3] = 16'h0001;                   // Carry out
                startProgram();
                for (int i = 0; i < 4; i++) begin
                        loadWord(1, a[i]);
                        loadWord(2, b[i]);
                        rOp(isaPkg::OpSeq, 1, 2, 3, 2'd0, {15'b0, a[i] == b[i]});
                        // Offset binary turns the signed order into an unsigned one
                        rOp(isaPkg::OpSlt, 1, 2, 4, 2'd0,
                            {15'b0, (a[i] ^ 16'h8000) < (b[i] ^ 16'h8000)});
                        rOp(isaPkg::OpSle, 1, 2, 5, 2'd0,
                            {15'b0, (a[i] ^ 16'h8000) <= (b[i] ^ 16'h8000)});
                        rOp(isaPkg::OpSco, 1, 2, 6, 2'd0,
                            {15'b0, (int'(a[i]) + int'(b[i])) > 65535});
                end
                emitStop(16'h0000);
                runProgram("compare", 1'b1, 1'b0);
        endtask

        task automatic testMemory();
                isaPkg::word_t v;
                v = 16'($urandom);
                startProgram();
                lbi(1, 8'h10);
                loadWord(2, v);
                emit({isaPkg::OpSt, 3'd1, 3'd2, 5'd4});   // mem[0x14] = r2
                iOp(isaPkg::OpLd, 1, 3, 5'd4, v);
                emit({isaPkg::OpStu, 3'd1, 3'd2, 5'd6});  // mem[0x16] = r2, r1 = 0x16
                setReg(1, 16'h0016);
                iOp(isaPkg::OpLd, 1, 4, 5'd0, v);
                emitStop(16'h0000);
                runProgram("memory", 1'b1, 1'b0);
        endtask

        task automatic testControl();
                isaPkg::word_t t;
                startProgram();
                lbi(1, 8'h00);
                emit({isaPkg::OpBeqz, 3'd1, 8'd2});
                skipped();
                emit({isaPkg::OpBnez, 3'd1, 8'd2});
                lbi(2, 8'h01);
                emit({isaPkg::OpBeqz, 3'd2, 8'd2});
                emit({isaPkg::OpBltz, 3'd2, 8'd2});
                lbi(3, 8'hff);
                emit({isaPkg::OpBltz, 3'd3, 8'd2});
                skipped();
                emit({isaPkg::OpBgez, 3'd3, 8'd2});
                lbi(4, 8'h07);
                emit({isaPkg::OpBgez, 3'd4, 8'd2});
                skipped();
                emit({isaPkg::OpBnez, 3'd4, 8'd2});
                skipped();
                emit({isaPkg::OpJ, 11'd2});
                skipped();
                t = 16'(2 * progLen + 2);                  // Return address of JAL
                emit({isaPkg::OpJal, 11'd2});
                setReg(7, t);
                skipped();
                t = 16'(2 * progLen + 6);                  // Past the JR and one slot
                lbi(5, t[7:0]);
                emit({isaPkg::OpJr, 3'd5, 8'd0});
                skipped();
                t = 16'(2 * progLen + 6);
                lbi(5, t[7:0]);
                t = 16'(2 * progLen + 2);
                emit({isaPkg::OpJalr, 3'd5, 8'd0});
                setReg(7, t);
                skipped();
                lbi(2, 8'h33);
                emitStop(16'h0000);
                runProgram("control", 1'b1, 1'b0);
        endtask

        task automatic testStop();
                startProgram();
                lbi(1, 8'h05);
                emitStop(16'h0000);
                skipped();
                runProgram("halt", 1'b1, 1'b0);
                startProgram();
                lbi(1, 8'h03);
                emitStop({5'b00010, 3'd1, 8'h07});         // Undefined opcode
                skipped();
                runProgram("undefined", 1'b0, 1'b1);
        endtask

        initial begin
                void'($urandom(32'h13afcfaf));
                rstN = 1'b0;
                startProgram();
                testImmediate();
                testRegister();
                testCompare();
                testMemory();
                testControl();
                testStop();
                $display("Regression passed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== project.f ====
hw/isaPkg.sv
hw/ctrlDecode.sv
hw/regFile.sv
hw/aluUnit.sv
hw/nextPc.sv
hw/dataMem.sv
hw/cpuCore.sv
dv/cpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= project.f
LINTFLAGS ?= --lint-only -Wall --timing
SIMFLAGS  ?= --binary --timing --assert
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
